/* design/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // instruction class, taken from opcode[6:2]
  typedef enum logic [4:0] {
    op_load     = 5'b00000,
    op_calc_imm = 5'b00100,
    op_auipc    = 5'b00101,
    op_store    = 5'b01000,
    op_calc_reg = 5'b01100,
    op_lui      = 5'b01101,
    op_branch   = 5'b11000,
    op_jalr     = 5'b11001,
    op_jal      = 5'b11011,
    op_sys      = 5'b11100
  } op_e;

  // branch conditions, funct3 of the branch opcode
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } br_funct_e;

  // alu operation select, same as funct3 of op/op-imm
  localparam logic [2:0] alu_add  = 3'b000; // sub with alt
  localparam logic [2:0] alu_sll  = 3'b001;
  localparam logic [2:0] alu_slt  = 3'b010;
  localparam logic [2:0] alu_sltu = 3'b011;
  localparam logic [2:0] alu_xor  = 3'b100;
  localparam logic [2:0] alu_srl  = 3'b101; // sra with alt
  localparam logic [2:0] alu_or   = 3'b110;
  localparam logic [2:0] alu_and  = 3'b111;

  // funct3 of the system opcode
  localparam logic [2:0] sys_priv  = 3'b000; // ecall / mret
  localparam logic [2:0] sys_csrrw = 3'b001;
  localparam logic [2:0] sys_csrrs = 3'b010;
  localparam logic [2:0] sys_csrrc = 3'b011;

  // machine csr numbers
  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  // mstatus bit positions
  localparam int mstatus_mie  = 3;
  localparam int mstatus_mpie = 7;

  // immediates that tell the privileged instructions apart
  localparam logic [11:0] ecall_imm = 12'h000;
  localparam logic [11:0] mret_imm  = 12'h302;

  localparam logic [31:0] cause_ecall_m = 32'd11; // environment call from m-mode

endpackage

`default_nettype wire

/* design/exec_pkg.sv */
`default_nettype none

package exec_pkg;

  // csr view of the immediate word
  typedef struct packed {
    logic [19:0] upper;
    logic [11:0] addr;   // csr number, or ecall/mret marker
  } imm_csr_t;

  // offset for most classes, csr number for sys
  typedef union packed {
    logic [31:0] word;
    imm_csr_t    csr;
  } imm_u;

  // one decoded instruction from the decoder
  typedef struct packed {
    logic [31:0]     pc;
    rv_isa_pkg::op_e op;
    logic [2:0]      funct;     // funct3, passed to memory as size/sign
    logic [4:0]      rd;
    logic [31:0]     src1;
    logic [31:0]     src2;
    imm_u            imm;
    logic [31:0]     alu_a;     // operands already picked by decode
    logic [31:0]     alu_b;
    logic [2:0]      alu_funct;
    logic            alu_alt;   // sub / sra
  } issue_t;

  // load or store request
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  funct;
    logic [31:0] wdata;
    logic        write;
  } mem_req_t;

  // register write-back
  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_t;

  // single csr write
  typedef struct packed {
    logic [11:0] addr;
    logic [31:0] data;
  } csr_wr_t;

endpackage

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic [2:0]  funct,
  input  logic        alt,
  output logic [31:0] result
);
  import rv_isa_pkg::*;

  logic [4:0]  shamt;
  logic [31:0] sum;
  logic        lt_s;
  logic        lt_u;

  assign shamt = b[4:0]; // rv32 uses the low five bits only

  // shared adder, also feeds the beq/bne zero test
  assign sum  = alt ? a - b : a + b;
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    case (funct)
      alu_add: begin
        result = sum;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_slt: begin
        result = {31'b0, lt_s};
      end
      alu_sltu: begin
        result = {31'b0, lt_u};
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_srl: begin
        // arithmetic shift keeps the sign bit
        result = alt ? 32'($signed(a) >>> shamt) : a >> shamt;
      end
      alu_or: begin
        result = a | b;
      end
      alu_and: begin
        result = a & b;
      end
      default: begin
        result = sum;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
  parameter logic [31:0] mtvec_reset = 32'h0000_0100
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [11:0]       raddr,
  output logic [31:0]       rdata,
  input  logic              wen1,
  input  logic              wen2,
  input  exec_pkg::csr_wr_t wr1,
  input  exec_pkg::csr_wr_t wr2,
  input  logic              ecall_take,
  input  logic              mret_take
);
  import rv_isa_pkg::*;

  localparam int n_csr       = 4;
  localparam int idx_mstatus = 0;
  localparam int idx_mtvec   = 1;
  localparam int idx_mepc    = 2;
  localparam int idx_mcause  = 3;

  // {mcause, mepc, mtvec, mstatus}
  localparam logic [n_csr-1:0][31:0] csr_reset = {32'd0, 32'd0, mtvec_reset, 32'd0};

  logic [n_csr-1:0][31:0] csr_q;
  logic [n_csr-1:0][31:0] csr_d;
  logic [n_csr-1:0]       rsel;
  logic [n_csr-1:0]       wsel1;
  logic [n_csr-1:0]       wsel2;

  // one-hot select, all zero for an unimplemented csr
  function automatic logic [n_csr-1:0] csr_sel(input logic [11:0] addr);
    logic [n_csr-1:0] sel;
    sel = '0;
    case (addr)
      csr_mstatus: sel[idx_mstatus] = 1'b1;
      csr_mtvec:   sel[idx_mtvec]   = 1'b1;
      csr_mepc:    sel[idx_mepc]    = 1'b1;
      csr_mcause:  sel[idx_mcause]  = 1'b1;
      default:     sel = '0;
    endcase
    return sel;
  endfunction

  assign rsel  = csr_sel(raddr);
  assign wsel1 = csr_sel(wr1.addr);
  assign wsel2 = csr_sel(wr2.addr);

  always_comb begin
    rdata = '0; // unknown csr reads as zero
    for (int i = 0; i < n_csr; i++) begin
      if (rsel[i]) rdata = csr_q[i];
    end
  end

  always_comb begin
    csr_d = csr_q;
    for (int i = 0; i < n_csr; i++) begin
      if (wen1 && wsel1[i]) csr_d[i] = wr1.data;
      if (wen2 && wsel2[i]) csr_d[i] = wr2.data; // port 2 wins on a clash
    end
    if (ecall_take) begin // trap entry stacks mie
      csr_d[idx_mstatus][mstatus_mpie] = csr_q[idx_mstatus][mstatus_mie];
      csr_d[idx_mstatus][mstatus_mie]  = 1'b0;
    end
    if (mret_take) begin
      csr_d[idx_mstatus][mstatus_mie]  = csr_q[idx_mstatus][mstatus_mpie];
      csr_d[idx_mstatus][mstatus_mpie] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      csr_q <= csr_reset;
    end else begin
      csr_q <= csr_d;
    end
  end

  // exec_unit decodes these from one instruction, they must be exclusive
  a_trap_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(ecall_take && mret_take))
    else $error("ecall_take and mret_take high together");

endmodule

`default_nettype wire

/* design/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               issue_valid,
  output logic               issue_ready,
  input  exec_pkg::issue_t   issue,
  output logic [31:0]        npc,
  output logic               wb_valid,
  output exec_pkg::wb_t      wb,
  output logic [11:0]        csr_raddr,
  input  logic [31:0]        csr_rdata,
  output logic               csr_wen1,
  output logic               csr_wen2,
  output exec_pkg::csr_wr_t  csr_wr1,
  output exec_pkg::csr_wr_t  csr_wr2,
  output logic               ecall_take,
  output logic               mret_take,
  output logic               mem_req_valid,
  input  logic               mem_req_ready,
  output exec_pkg::mem_req_t mem_req,
  input  logic               mem_rsp_valid,
  input  logic [31:0]        mem_rsp_data
);
  import rv_isa_pkg::*;
  import exec_pkg::*;

  logic [11:0] csr_addr;
  logic        is_sys;
  logic        is_csr_op;
  logic        is_ecall;
  logic        is_mret;
  logic        is_load;
  logic        is_store;
  logic        is_mem;
  logic [31:0] csr_val;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [2:0]  alu_funct;
  logic        alu_alt;
  logic [31:0] alu_res;
  logic        br_take;
  logic [31:0] npc_raw;
  logic        gpr_wen;
  logic [31:0] gpr_wdata;
  logic        issue_hs;
  logic        busy;      // memory access outstanding
  logic        pend_load;
  logic [4:0]  pend_rd;

  assign csr_addr  = issue.imm.csr.addr;
  assign is_sys    = issue.op == op_sys;
  assign is_csr_op = is_sys && (issue.funct != sys_priv);
  assign is_ecall  = is_sys && (issue.funct == sys_priv) && (csr_addr == ecall_imm);
  assign is_mret   = is_sys && (issue.funct == sys_priv) && (csr_addr == mret_imm);
  assign is_load   = issue.op == op_load;
  assign is_store  = issue.op == op_store;
  assign is_mem    = is_load || is_store;

  // trap instructions read their jump target
  always_comb begin
    csr_raddr = csr_addr;
    if (is_ecall) csr_raddr = csr_mtvec;
    else if (is_mret) csr_raddr = csr_mepc;
  end

  // writes from the previous instruction land in csr_file one edge late
  always_comb begin
    csr_val = csr_rdata;
    if (csr_wen1 && (csr_wr1.addr == csr_raddr)) csr_val = csr_wr1.data;
    if (csr_wen2 && (csr_wr2.addr == csr_raddr)) csr_val = csr_wr2.data;
  end

  // sys ops build their own operands around the csr value
  always_comb begin
    alu_a     = issue.alu_a;
    alu_b     = issue.alu_b;
    alu_funct = issue.alu_funct;
    alu_alt   = issue.alu_alt;
    if (is_sys) begin
      alu_alt = 1'b0;
      case (issue.funct)
        sys_csrrw: begin
          alu_a     = '0;
          alu_b     = issue.src1;
          alu_funct = alu_add;
        end
        sys_csrrs: begin
          alu_a     = csr_val;
          alu_b     = issue.src1;
          alu_funct = alu_or;
        end
        sys_csrrc: begin
          alu_a     = csr_val;
          alu_b     = ~issue.src1;
          alu_funct = alu_and;
        end
        default: begin // ecall saves pc
          alu_a     = issue.pc;
          alu_b     = '0;
          alu_funct = alu_add;
        end
      endcase
    end
  end

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .funct  (alu_funct),
    .alt    (alu_alt),
    .result (alu_res)
  );

  always_comb begin
    case (br_funct_e'(issue.funct))
      br_beq:          br_take = alu_res == '0;
      br_bne:          br_take = alu_res != '0;
      br_blt, br_bltu: br_take = alu_res[0];
      br_bge, br_bgeu: br_take = !alu_res[0];
      default:         br_take = 1'b0;
    endcase
  end

  always_comb begin
    npc_raw = issue.pc + 32'd4;
    case (issue.op)
      op_jal:    npc_raw = issue.pc + issue.imm.word;
      op_jalr:   npc_raw = issue.src1 + issue.imm.word;
      op_branch: if (br_take) npc_raw = issue.pc + issue.imm.word;
      op_sys:    if (is_ecall || is_mret) npc_raw = csr_val;
      default:   npc_raw = issue.pc + 32'd4;
    endcase
  end
  assign npc = {npc_raw[31:1], 1'b0};

  // load data is picked up later from the response
  always_comb begin
    gpr_wen   = 1'b0;
    gpr_wdata = alu_res;
    case (issue.op)
      op_lui, op_auipc, op_jal, op_jalr, op_calc_imm, op_calc_reg: gpr_wen = 1'b1;
      op_sys: begin
        gpr_wen   = is_csr_op;
        gpr_wdata = csr_val; // old csr value
      end
      default: gpr_wen = 1'b0;
    endcase
  end

  assign issue_ready   = !busy && (!is_mem || mem_req_ready);
  assign issue_hs      = issue_valid && issue_ready;
  assign mem_req_valid = issue_valid && is_mem && !busy;

  always_comb begin
    mem_req.addr  = alu_res;
    mem_req.funct = issue.funct;
    mem_req.wdata = issue.src2;
    mem_req.write = is_store;
  end

  assign csr_wr2.addr = csr_mcause; // port 2 only serves ecall
  assign csr_wr2.data = cause_ecall_m;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy       <= 1'b0;
      pend_load  <= 1'b0;
      wb_valid   <= 1'b0;
      csr_wen1   <= 1'b0;
      csr_wen2   <= 1'b0;
      ecall_take <= 1'b0;
      mret_take  <= 1'b0;
    end else begin
      wb_valid   <= (issue_hs && gpr_wen) || (mem_rsp_valid && pend_load);
      csr_wen1   <= issue_hs && (is_csr_op || is_ecall);
      csr_wen2   <= issue_hs && is_ecall;
      ecall_take <= issue_hs && is_ecall;
      mret_take  <= issue_hs && is_mret;
      if (issue_hs && is_mem) begin
        busy      <= 1'b1;
        pend_load <= is_load;
      end else if (mem_rsp_valid) begin
        busy      <= 1'b0;
        pend_load <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_hs) begin
      wb.rd        <= issue.rd;
      wb.data      <= gpr_wdata;
      csr_wr1.addr <= is_ecall ? csr_mepc : csr_addr;
      csr_wr1.data <= alu_res;
      if (is_load) pend_rd <= issue.rd;
    end else if (mem_rsp_valid && pend_load) begin
      wb.rd   <= pend_rd;
      wb.data <= mem_rsp_data;
    end
  end

  a_no_rsp_idle: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rsp_valid |-> busy)
    else $error("memory response with no request outstanding");

endmodule

`default_nettype wire

/* design/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_top #(
  parameter logic [31:0] mtvec_reset = 32'h0000_0100
) (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               issue_valid,
  output logic               issue_ready,
  input  exec_pkg::issue_t   issue,
  output logic [31:0]        npc,
  output logic               wb_valid,
  output exec_pkg::wb_t      wb,
  output logic               mem_req_valid,
  input  logic               mem_req_ready,
  output exec_pkg::mem_req_t mem_req,
  input  logic               mem_rsp_valid,
  input  logic [31:0]        mem_rsp_data
);
  import exec_pkg::*;

  logic [11:0] csr_raddr;
  logic [31:0] csr_rdata;
  logic        csr_wen1;
  logic        csr_wen2;
  csr_wr_t     csr_wr1;  // csr op result, or pc into mepc
  csr_wr_t     csr_wr2;  // ecall cause
  logic        ecall_take;
  logic        mret_take;

  exec_unit u_exec_unit (
    .clk           (clk),
    .arst_n        (arst_n),
    .issue_valid   (issue_valid),
    .issue_ready   (issue_ready),
    .issue         (issue),
    .npc           (npc),
    .wb_valid      (wb_valid),
    .wb            (wb),
    .csr_raddr     (csr_raddr),
    .csr_rdata     (csr_rdata),
    .csr_wen1      (csr_wen1),
    .csr_wen2      (csr_wen2),
    .csr_wr1       (csr_wr1),
    .csr_wr2       (csr_wr2),
    .ecall_take    (ecall_take),
    .mret_take     (mret_take),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data)
  );

  csr_file #(
    .mtvec_reset (mtvec_reset)
  ) u_csr_file (
    .clk        (clk),
    .arst_n     (arst_n),
    .raddr      (csr_raddr),
    .rdata      (csr_rdata),
    .wen1       (csr_wen1),
    .wen2       (csr_wen2),
    .wr1        (csr_wr1),
    .wr2        (csr_wr2),
    .ecall_take (ecall_take),
    .mret_take  (mret_take)
  );

endmodule

`default_nettype wire

/* verif/exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_tb;
  import rv_isa_pkg::*;
  import exec_pkg::*;

  localparam int n_rec = 23;
  localparam int n_fld = 18;  // hex words per golden line
  localparam int timeout_cycles = 8 * n_rec + 50;
  localparam logic [31:0] mtvec_init = 32'h0000_0200;

  // one golden line, unpacked
  typedef struct packed {
    issue_t      ins;
    logic [31:0] rdata;     // memory read value
    logic [31:0] npc;
    logic        wb;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        req;
    logic [31:0] req_addr;
  } golden_rec_t;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        issue_valid;
  logic        issue_ready;
  issue_t      issue;
  logic [31:0] npc;
  logic        wb_valid;
  wb_t         wb;
  logic        mem_req_valid;
  logic        mem_req_ready;
  mem_req_t    mem_req;
  logic        mem_rsp_valid;
  logic [31:0] mem_rsp_data;

  logic [31:0] golden [0:n_rec*n_fld-1];
  logic [31:0] lfsr;
  logic [31:0] rsp_value;   // read data for the access in flight
  int          cycles = 0;
  int          wb_strobes = 0;
  int          wb_expected;

  exec_top #(
    .mtvec_reset (mtvec_init)
  ) exec_top_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .issue_valid   (issue_valid),
    .issue_ready   (issue_ready),
    .issue         (issue),
    .npc           (npc),
    .wb_valid      (wb_valid),
    .wb            (wb),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req       (mem_req),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data)
  );

  always #5 clk = ~clk;

  // galois form, one step per bit drawn
  function automatic logic next_rand_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 32'hD000_0001;
    return out;
  endfunction

  function automatic golden_rec_t get_rec(input int i);
    golden_rec_t r;
    int          b;
    b               = i * n_fld;
    r.ins.pc        = golden[b];
    r.ins.op        = op_e'(golden[b+1][4:0]);
    r.ins.funct     = golden[b+2][2:0];
    r.ins.rd        = golden[b+3][4:0];
    r.ins.src1      = golden[b+4];
    r.ins.src2      = golden[b+5];
    r.ins.imm.word  = golden[b+6];
    r.ins.alu_a     = golden[b+7];
    r.ins.alu_b     = golden[b+8];
    r.ins.alu_funct = golden[b+9][2:0];
    r.ins.alu_alt   = golden[b+10][0];
    r.rdata         = golden[b+11];
    r.npc           = golden[b+12];
    r.wb            = golden[b+13][0];
    r.wb_rd         = golden[b+14][4:0];
    r.wb_data       = golden[b+15];
    r.req           = golden[b+16][0];
    r.req_addr      = golden[b+17];
    return r;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic run_record(input golden_rec_t r);
    logic done;
    issue       = r.ins;
    issue_valid = 1'b1;
    rsp_value   = r.rdata;
    done        = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = issue_ready;
    end
    // accept edge, outputs still hold the pre-edge values
    check_eq("npc", npc, r.npc);
    check_eq("mem_req_valid", 32'(mem_req_valid), 32'(r.req));
    if (r.req) begin
      check_eq("mem_req.addr", mem_req.addr, r.req_addr);
      check_eq("mem_req.write", 32'(mem_req.write), 32'(r.ins.op == op_store));
      check_eq("mem_req.funct", 32'(mem_req.funct), 32'(r.ins.funct));
      if (r.ins.op == op_store) check_eq("mem_req.wdata", mem_req.wdata, r.ins.src2);
    end
    @(negedge clk);
    issue_valid = 1'b0;
    if (r.req) begin
      done = 1'b0;
      while (!done) begin
        @(posedge clk);
        check_eq("issue_ready", 32'(issue_ready), 32'd0);  // stalled on the access
        check_eq("wb_valid", 32'(wb_valid), 32'd0);
        done = mem_rsp_valid;
      end
      @(negedge clk);
      check_eq("issue_ready", 32'(issue_ready), 32'd1);
    end
    check_eq("wb_valid", 32'(wb_valid), 32'(r.wb));
    if (r.wb) begin
      check_eq("wb.rd", 32'(wb.rd), 32'(r.wb_rd));
      check_eq("wb.data", wb.data, r.wb_data);
      wb_expected++;
    end
    @(negedge clk);
    check_eq("wb_valid", 32'(wb_valid), 32'd0);  // strobe lasts one cycle
  endtask

  // memory side, always ready, one access at a time
  initial begin : mem_responder
    logic [1:0] pick;
    int         delay;
    mem_req_ready = 1'b1;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    lfsr          = 32'hce69;
    forever begin
      @(posedge clk);
      if (arst_n && mem_req_valid && mem_req_ready) begin
        pick[0] = next_rand_bit();
        pick[1] = next_rand_bit();
        delay   = 1 + (int'(pick) % 3);
        repeat (delay) @(negedge clk);
        mem_rsp_valid = 1'b1;
        mem_rsp_data  = rsp_value;
        @(negedge clk);
        mem_rsp_valid = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (arst_n && wb_valid) wb_strobes <= wb_strobes + 1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("run timed out after %0d cycles", cycles);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin : main
    golden_rec_t r;
    arst_n      = 1'b0;
    issue_valid = 1'b0;
    issue       = '0;
    wb_expected = 0;
    $readmemh("verif/exec_golden.txt", golden);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_eq("issue_ready", 32'(issue_ready), 32'd1);
    check_eq("wb_valid", 32'(wb_valid), 32'd0);
    check_eq("mem_req_valid", 32'(mem_req_valid), 32'd0);
    arst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < n_rec; i++) begin
      r = get_rec(i);
      run_record(r);
    end
    check_eq("wb_strobe_count", wb_strobes, wb_expected);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/exec_golden.txt */
// pc op funct rd src1 src2 imm alu_a alu_b alu_funct alu_alt mem_rdata
// exp_npc exp_wb exp_rd exp_wb_data exp_req exp_req_addr, all hex, one instruction per line
1000 04 0 01 5 0 7 5 7 0 0 0 1004 1 01 C 0 0
1004 0C 0 02 A 3 0 A 3 0 1 0 1008 1 02 7 0 0
1008 0C 5 03 F0000000 4 0 F0000000 4 5 1 0 100C 1 03 FF000000 0 0
100C 04 2 04 FFFFFFFF 0 1 FFFFFFFF 1 2 0 0 1010 1 04 1 0 0
1010 0D 0 05 0 0 12345000 0 12345000 0 0 0 1014 1 05 12345000 0 0
1014 05 0 06 0 0 2000 1014 2000 0 0 0 1018 1 06 3014 0 0
1018 1B 0 01 0 0 100 1018 4 0 0 0 1118 1 01 101C 0 0
1118 19 0 07 2001 0 4 1118 4 0 0 0 2004 1 07 111C 0 0
2004 18 0 00 5 5 10 5 5 0 1 0 2014 0 0 0 0 0
2014 18 1 00 5 5 10 5 5 0 1 0 2018 0 0 0 0 0
2018 18 4 00 FFFFFFFE 1 10 FFFFFFFE 1 2 0 0 2028 0 0 0 0 0
2028 18 5 00 FFFFFFFE 1 10 FFFFFFFE 1 2 0 0 202C 0 0 0 0 0
202C 18 6 00 FFFFFFFE 1 10 FFFFFFFE 1 3 0 0 2030 0 0 0 0 0
2030 18 7 00 FFFFFFFE 1 10 FFFFFFFE 1 3 0 0 2040 0 0 0 0 0
2040 00 2 08 3000 0 8 3000 8 0 0 DEADBEEF 2044 1 08 DEADBEEF 1 3008
2044 08 2 00 3000 CAFEF00D C 3000 C 0 0 0 2048 0 0 0 1 300C
2048 1C 1 09 400 0 305 0 0 0 0 0 204C 1 09 200 0 0
204C 1C 2 0A 0 0 305 0 0 0 0 0 2050 1 0A 400 0 0
2050 1C 0 00 0 0 0 0 0 0 0 0 400 0 0 0 0 0
400 1C 2 0B 0 0 341 0 0 0 0 0 404 1 0B 2050 0 0
404 1C 2 0C 0 0 342 0 0 0 0 0 408 1 0C B 0 0
408 1C 0 00 0 0 302 0 0 0 0 0 2050 0 0 0 0 0
2050 00 2 0D 3000 0 10 3000 10 0 0 0BADF00D 2054 1 0D 0BADF00D 1 3010

/* build.f */
design/rv_isa_pkg.sv
design/exec_pkg.sv
design/alu.sv
design/csr_file.sv
design/exec_unit.sv
design/exec_top.sv
verif/exec_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f build.f --top-module exec_tb

sim_out=$(./obj_dir/Vexec_tb 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST OK"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
